//--- hw/bpu_types_pkg.sv
// branch kinds, table line format and default sizes shared by the branch prediction unit
package bpu_types_pkg;

  // default geometry that bpu_top passes down
  localparam int DEF_INDEX_BITS  = 8;
  localparam int DEF_TAG_BITS    = 10;
  localparam int DEF_RAS_DEPTH   = 8;
  localparam int DEF_QUEUE_DEPTH = 8;

  // encoding follows the execute stage
  typedef enum logic [1:0] {
    JK_BRANCH   = 2'b00,
    JK_CALL     = 2'b01, // bl
    JK_RETURN   = 2'b10, // jirl through ra
    JK_INDIRECT = 2'b11
  } jump_kind_e;

  // one line of the target buffer plus its counter
  typedef struct packed {
    logic                    valid;
    jump_kind_e              kind;
    logic [DEF_TAG_BITS-1:0] tag;
    logic [29:0]             target; // word address
    logic [1:0]              cnt;    // 2 and up predicts taken
  } btb_entry_t;

endpackage

//--- hw/bpu_bus_pkg.sv
// structs for the execute resolve reports and the prediction handed back to fetch
package bpu_bus_pkg;

  import bpu_types_pkg::*;

  // one resolved instruction from an execute slot
  typedef struct packed {
    logic        valid;    // real branch and not an exception or ertn
    logic        flush;    // execute flushes the pipe
    logic [31:0] pc;
    logic        taken;
    logic        pred_hit; // fetch marked it as a jump
    logic        dir_miss; // execute redirects on its own
    logic [31:0] target;
    jump_kind_e  kind;
  } resolve_t;

  // answer for the current fetch group
  typedef struct packed {
    logic [31:0] next_pc;
    logic [3:0]  slot_valid;
    logic [3:0]  slot_jump; // one-hot or zero
  } fetch_pred_t;

endpackage

//--- hw/btb_pht.sv
// tagged target buffer with 2-bit counters; looks up a four-slot fetch group and trains from execute
module btb_pht
  import bpu_types_pkg::*, bpu_bus_pkg::*;
#(
  parameter int INDEX_BITS = DEF_INDEX_BITS
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] pc,
  input  logic [29:0] ras_top,
  input  logic        ras_empty,
  input  resolve_t    res1,
  input  resolve_t    res2,
  input  logic        flush_by1,
  output fetch_pred_t pred,
  output logic        pred_ret
);

  localparam int ENTRIES = 2 ** INDEX_BITS;

  btb_entry_t table_q [ENTRIES];

  // lookup side
  logic [INDEX_BITS-1:0]   base_idx;
  logic [DEF_TAG_BITS-1:0] rd_tag;
  logic [3:0]              live;
  logic [3:0]              slot_hit;
  logic [3:0]              first_hit;
  btb_entry_t              rd_entry [4];
  btb_entry_t              jump_entry;

  // training side
  logic [INDEX_BITS-1:0]   w_idx1;
  logic [INDEX_BITS-1:0]   w_idx2;
  logic [DEF_TAG_BITS-1:0] w_tag1;
  logic [DEF_TAG_BITS-1:0] w_tag2;
  logic                    hit1;
  logic                    hit2;
  logic                    we1;
  logic                    we2;
  btb_entry_t              nxt1;
  btb_entry_t              nxt2;

  // next value of a line after one resolved branch
  function automatic btb_entry_t train_line(input btb_entry_t cur, input resolve_t r,
                                            input logic [DEF_TAG_BITS-1:0] tag,
                                            input logic hit);
    btb_entry_t nxt;
    nxt = cur;
    if (r.taken)
    begin
      nxt.valid  = 1'b1;
      nxt.kind   = r.kind;
      nxt.tag    = tag;
      nxt.target = r.target[31:2];
      if (!hit)
        nxt.cnt = 2'd2; // fresh line starts weakly taken
      else if (cur.cnt != 2'd3)
        nxt.cnt = cur.cnt + 2'd1;
    end
    else if (hit && cur.cnt != 2'd0)
    begin
      nxt.cnt = cur.cnt - 2'd1;
    end
    return nxt;
  endfunction

  assign base_idx = {pc[INDEX_BITS+1:4], 2'b00}; // group aligned
  assign rd_tag   = pc[INDEX_BITS+2 +: DEF_TAG_BITS];
  assign live     = 4'b1111 << pc[3:2];

  always_comb
  begin
    for (int k = 0; k < 4; k++)
    begin
      rd_entry[k] = table_q[base_idx | INDEX_BITS'(k)];
      slot_hit[k] = live[k] && rd_entry[k].valid && (rd_entry[k].tag == rd_tag)
                    && (rd_entry[k].cnt >= 2'd2);
    end
  end

  assign first_hit = slot_hit & (~slot_hit + 4'd1); // lowest set bit

  always_comb
  begin
    jump_entry = rd_entry[0];
    for (int k = 1; k < 4; k++)
    begin
      if (first_hit[k])
        jump_entry = rd_entry[k];
    end
  end

  assign pred_ret = (|first_hit) && (jump_entry.kind == JK_RETURN) && !ras_empty;

  always_comb
  begin
    pred.slot_jump = first_hit;
    if (|first_hit)
    begin
      pred.slot_valid = live & (first_hit | (first_hit - 4'd1)); // cut after the jump
      pred.next_pc    = pred_ret ? {ras_top, 2'b00} : {jump_entry.target, 2'b00};
    end
    else
    begin
      pred.slot_valid = live;
      pred.next_pc    = {pc[31:4] + 28'd1, 4'b0000};
    end
  end

  assign w_idx1 = res1.pc[INDEX_BITS+1:2];
  assign w_idx2 = res2.pc[INDEX_BITS+1:2];
  assign w_tag1 = res1.pc[INDEX_BITS+2 +: DEF_TAG_BITS];
  assign w_tag2 = res2.pc[INDEX_BITS+2 +: DEF_TAG_BITS];

  assign hit1 = table_q[w_idx1].valid && (table_q[w_idx1].tag == w_tag1);
  assign hit2 = table_q[w_idx2].valid && (table_q[w_idx2].tag == w_tag2);

  assign nxt1 = train_line(table_q[w_idx1], res1, w_tag1, hit1);
  assign nxt2 = train_line(table_q[w_idx2], res2, w_tag2, hit2);

  // not-taken misses leave the table alone
  assign we1 = res1.valid && (res1.taken || hit1);
  // res2 is on the wrong path once res1 redirected
  assign we2 = res2.valid && !flush_by1 && (res2.taken || hit2);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < ENTRIES; i++)
        table_q[i].valid <= 1'b0;
    end
    else
    begin
      if (we1)
        table_q[w_idx1] <= nxt1;
      if (we2)
        table_q[w_idx2] <= nxt2; // younger slot wins on a shared index
    end
  end

endmodule

//--- hw/return_stack.sv
// circular return address stack, pushed by resolved calls and popped by resolved returns
module return_stack
  import bpu_types_pkg::*, bpu_bus_pkg::*;
#(
  parameter int RAS_DEPTH = DEF_RAS_DEPTH
) (
  input  logic        clk,
  input  logic        reset,
  input  resolve_t    res1,
  input  resolve_t    res2,
  input  logic        no_pop1,
  input  logic        no_pop2,
  output logic [29:0] top,
  output logic        empty
);

  localparam int PTR_BITS = $clog2(RAS_DEPTH);
  localparam int CNT_BITS = $clog2(RAS_DEPTH + 1);

  logic [29:0]         stack_q [RAS_DEPTH];
  logic [PTR_BITS-1:0] ptr_q; // next free slot
  logic [PTR_BITS-1:0] ptr_mid;
  logic [PTR_BITS-1:0] ptr_d;
  logic [CNT_BITS-1:0] cnt_q;
  logic [CNT_BITS-1:0] cnt_mid;
  logic [CNT_BITS-1:0] cnt_d;
  logic                push1;
  logic                push2;
  logic                pop1;
  logic                pop2;

  function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] p);
    return (p == PTR_BITS'(RAS_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  function automatic logic [PTR_BITS-1:0] ptr_dec(input logic [PTR_BITS-1:0] p);
    return (p == '0) ? PTR_BITS'(RAS_DEPTH - 1) : p - 1'b1;
  endfunction

  assign push1 = res1.valid && res1.taken && (res1.kind == JK_CALL);
  assign push2 = res2.valid && res2.taken && (res2.kind == JK_CALL);
  assign pop1  = res1.valid && res1.taken && (res1.kind == JK_RETURN) && !no_pop1;
  assign pop2  = res2.valid && res2.taken && (res2.kind == JK_RETURN) && !no_pop2;

  // res1 first, then res2 on top of it
  always_comb
  begin
    ptr_mid = ptr_q;
    cnt_mid = cnt_q;
    if (push1)
    begin
      ptr_mid = ptr_inc(ptr_q);
      if (cnt_q != CNT_BITS'(RAS_DEPTH))
        cnt_mid = cnt_q + 1'b1; // full stack overwrites the oldest
    end
    else if (pop1 && cnt_q != '0)
    begin
      ptr_mid = ptr_dec(ptr_q);
      cnt_mid = cnt_q - 1'b1;
    end
    ptr_d = ptr_mid;
    cnt_d = cnt_mid;
    if (push2)
    begin
      ptr_d = ptr_inc(ptr_mid);
      if (cnt_mid != CNT_BITS'(RAS_DEPTH))
        cnt_d = cnt_mid + 1'b1;
    end
    else if (pop2 && cnt_mid != '0)
    begin
      ptr_d = ptr_dec(ptr_mid);
      cnt_d = cnt_mid - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ptr_q <= '0;
      cnt_q <= '0;
    end
    else
    begin
      ptr_q <= ptr_d;
      cnt_q <= cnt_d;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push1)
      stack_q[ptr_q] <= res1.pc[31:2] + 30'd1;
    if (push2)
      stack_q[ptr_mid] <= res2.pc[31:2] + 30'd1;
  end

  assign top   = stack_q[ptr_dec(ptr_q)];
  assign empty = (cnt_q == '0);

endmodule

//--- hw/target_queue.sv
// FIFO of predicted jump targets; checks them against execute and raises a redirect on mismatch
module target_queue
  import bpu_types_pkg::*, bpu_bus_pkg::*;
#(
  parameter int QUEUE_DEPTH = DEF_QUEUE_DEPTH
) (
  input  logic        clk,
  input  logic        reset,
  input  fetch_pred_t pred,
  input  logic        install,
  input  resolve_t    res1,
  input  resolve_t    res2,
  output logic        bpu_flush,
  output logic [31:0] bpu_jump_pc,
  output logic        no_pop1,
  output logic        no_pop2
);

  localparam int PTR_BITS = $clog2(QUEUE_DEPTH);
  localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1);

  logic [29:0]         queue_q [QUEUE_DEPTH];
  logic [PTR_BITS-1:0] head_q;
  logic [PTR_BITS-1:0] tail_q;
  logic [PTR_BITS-1:0] head2;
  logic [CNT_BITS-1:0] cnt_q;
  logic [CNT_BITS-1:0] pops;
  logic                check1;
  logic                check2;
  logic                avail2;
  logic                mismatch1;
  logic                mismatch2;
  logic                match1;
  logic                match2;
  logic                push;
  logic                clear;

  function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] p);
    return (p == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign check1    = res1.valid && res1.taken && res1.pred_hit && !res1.dir_miss
                     && (cnt_q != '0);
  assign mismatch1 = check1 && (res1.target[31:2] != queue_q[head_q]);
  assign match1    = check1 && !mismatch1;

  // res2 sees the head that res1 left behind
  assign head2     = match1 ? ptr_inc(head_q) : head_q;
  assign avail2    = match1 ? (cnt_q > CNT_BITS'(1)) : (cnt_q != '0);
  assign check2    = res2.valid && res2.taken && res2.pred_hit && !res2.dir_miss
                     && avail2 && !mismatch1;
  assign mismatch2 = check2 && (res2.target[31:2] != queue_q[head2]);
  assign match2    = check2 && !mismatch2;

  assign bpu_flush   = mismatch1 || mismatch2;
  assign bpu_jump_pc = mismatch1 ? res1.target : res2.target;
  assign no_pop1     = mismatch1;
  assign no_pop2     = mismatch2;

  assign pops  = CNT_BITS'(match1) + CNT_BITS'(match2);
  assign clear = res1.flush || res2.flush || bpu_flush;
  assign push  = (|pred.slot_jump) && !install
                 && ((cnt_q - pops) != CNT_BITS'(QUEUE_DEPTH)); // drop when full

  always_ff @(posedge clk)
  begin
    if (reset || clear)
    begin
      head_q <= '0;
      tail_q <= '0;
      cnt_q  <= '0;
    end
    else
    begin
      head_q <= match2 ? ptr_inc(head2) : head2;
      if (push)
        tail_q <= ptr_inc(tail_q);
      cnt_q <= cnt_q - pops + CNT_BITS'(push);
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      queue_q[tail_q] <= pred.next_pc[31:2];
  end

endmodule

//--- hw/bpu_top.sv
// branch prediction unit for the fetch stage; connects target buffer, return stack and target queue
module bpu_top
  import bpu_types_pkg::*, bpu_bus_pkg::*;
#(
  parameter int INDEX_BITS  = DEF_INDEX_BITS,
  parameter int RAS_DEPTH   = DEF_RAS_DEPTH,
  parameter int QUEUE_DEPTH = DEF_QUEUE_DEPTH
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] pc,
  input  logic        install, // fetch stall
  input  resolve_t    res1,    // older slot
  input  resolve_t    res2,
  output fetch_pred_t pred,
  output logic        bpu_flush,
  output logic [31:0] bpu_jump_pc
);

  logic [29:0] ras_top;
  logic        ras_empty;
  logic        no_pop1;
  logic        no_pop2;

  btb_pht #(
    .INDEX_BITS (INDEX_BITS)
  ) u_btb_pht (
    .clk       (clk),
    .reset     (reset),
    .pc        (pc),
    .ras_top   (ras_top),
    .ras_empty (ras_empty),
    .res1      (res1),
    .res2      (res2),
    .flush_by1 (no_pop1), // res1 redirect squashes res2
    .pred      (pred),
    .pred_ret  ()         // set when the target came from the stack
  );

  return_stack #(
    .RAS_DEPTH (RAS_DEPTH)
  ) u_return_stack (
    .clk     (clk),
    .reset   (reset),
    .res1    (res1),
    .res2    (res2),
    .no_pop1 (no_pop1),
    .no_pop2 (no_pop2),
    .top     (ras_top),
    .empty   (ras_empty)
  );

  target_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_target_queue (
    .clk         (clk),
    .reset       (reset),
    .pred        (pred),
    .install     (install),
    .res1        (res1),
    .res2        (res2),
    .bpu_flush   (bpu_flush),
    .bpu_jump_pc (bpu_jump_pc),
    .no_pop1     (no_pop1),
    .no_pop2     (no_pop2)
  );

endmodule

//--- dv/bpu_tb.sv
// directed testbench for bpu_top, checks predictions against a model of the tables and the stack
module bpu_tb
  import bpu_types_pkg::*, bpu_bus_pkg::*;
();

  localparam int IB      = DEF_INDEX_BITS;
  localparam int ENTRIES = 2 ** IB;
  // reset, cold, training, tag, call and redirect tests
  localparam int BUDGET_CYCLES = 4 + 20 + 40 + 16 + 30 + 40;

  logic        clk = 1'b0;
  logic        reset;
  logic [31:0] pc;
  logic        install;
  resolve_t    res1;
  resolve_t    res2;
  fetch_pred_t pred;
  logic        bpu_flush;
  logic [31:0] bpu_jump_pc;
  logic [31:0] lfsr_state = 32'h0be7_1669;

  // reference copy of the target buffer and the return stack
  logic                    m_valid  [ENTRIES];
  jump_kind_e              m_kind   [ENTRIES];
  logic [DEF_TAG_BITS-1:0] m_tag    [ENTRIES];
  logic [29:0]             m_target [ENTRIES];
  logic [1:0]              m_cnt    [ENTRIES];
  logic [29:0]             ras_model [$];

  bpu_top UUT (
    .clk         (clk),
    .reset       (reset),
    .pc          (pc),
    .install     (install),
    .res1        (res1),
    .res2        (res2),
    .pred        (pred),
    .bpu_flush   (bpu_flush),
    .bpu_jump_pc (bpu_jump_pc)
  );

  always #2 clk = ~clk;

  initial
  begin
    #(4 * 2 * BUDGET_CYCLES); // twice the budget
    $display("timeout: the tests did not finish within %0d cycles", 2 * BUDGET_CYCLES);
    $display("Some tests failed");
    $fatal(1);
  end

  task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("error %s: expected %h, actual %h", name, expected, actual);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  // taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v          = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] rand_pc();
    return {rand_bits(30), 2'b00};
  endfunction

  function automatic resolve_t make_res(input logic [31:0] p, input logic taken,
                                        input logic [31:0] target, input jump_kind_e kind,
                                        input logic pred_hit);
    resolve_t r;
    r          = '0;
    r.valid    = 1'b1;
    r.pc       = p;
    r.taken    = taken;
    r.pred_hit = pred_hit;
    r.target   = target;
    r.kind     = kind;
    return r;
  endfunction

  function automatic fetch_pred_t expect_pred(input logic [31:0] p);
    fetch_pred_t e;
    logic [3:0]  live;
    int          idx;
    for (int k = 0; k < 4; k++)
      live[k] = (k >= p[3:2]);
    e.next_pc    = (p + 32'd16) & ~32'hf;
    e.slot_valid = live;
    e.slot_jump  = '0;
    for (int k = 0; k < 4; k++)
    begin
      idx = p[IB+1:4] * 4 + k;
      if (e.slot_jump == '0 && live[k] && m_valid[idx]
          && m_tag[idx] == p[IB+2 +: DEF_TAG_BITS] && m_cnt[idx] >= 2'd2)
      begin
        e.slot_jump[k] = 1'b1;
        e.slot_valid   = live & ((4'b0010 << k) - 4'd1);
        if (m_kind[idx] == JK_RETURN && ras_model.size() != 0)
          e.next_pc = {ras_model[$], 2'b00};
        else
          e.next_pc = {m_target[idx], 2'b00};
      end
    end
    return e;
  endfunction

  // both lines read before either is written, so res2 wins a shared index
  task automatic model_update(input resolve_t r1, input resolve_t r2, input logic redirect1);
    resolve_t    r       [2];
    logic        hit     [2];
    logic [1:0]  old_cnt [2];
    int          idx     [2];
    logic [31:0] ret_addr;
    r[0] = r1;
    r[1] = r2;
    for (int s = 0; s < 2; s++)
    begin
      idx[s]     = r[s].pc[IB+1:2];
      hit[s]     = m_valid[idx[s]] && m_tag[idx[s]] == r[s].pc[IB+2 +: DEF_TAG_BITS];
      old_cnt[s] = m_cnt[idx[s]];
    end
    for (int s = 0; s < 2; s++)
    begin
      if (r[s].valid && !(s == 1 && redirect1))
      begin
        if (r[s].taken)
        begin
          m_valid[idx[s]]  = 1'b1;
          m_kind[idx[s]]   = r[s].kind;
          m_tag[idx[s]]    = r[s].pc[IB+2 +: DEF_TAG_BITS];
          m_target[idx[s]] = r[s].target[31:2];
          m_cnt[idx[s]]    = !hit[s] ? 2'd2 : (old_cnt[s] == 2'd3 ? 2'd3 : old_cnt[s] + 2'd1);
        end
        else if (hit[s] && old_cnt[s] != 2'd0)
          m_cnt[idx[s]] = old_cnt[s] - 2'd1;
      end
    end
    for (int s = 0; s < 2; s++)
    begin
      if (r[s].valid && r[s].taken && r[s].kind == JK_CALL)
      begin
        if (ras_model.size() == DEF_RAS_DEPTH)
          void'(ras_model.pop_front()); // oldest overwritten
        ret_addr = r[s].pc + 32'd4;
        ras_model.push_back(ret_addr[31:2]);
      end
      else if (r[s].valid && r[s].taken && r[s].kind == JK_RETURN
               && !(s == 0 && redirect1) && ras_model.size() != 0)
        void'(ras_model.pop_back());
    end
  endtask

  task automatic lookup_check(input string name, input logic [31:0] p);
    fetch_pred_t e;
    @(posedge clk);
    pc <= p;
    @(negedge clk);
    e = expect_pred(p);
    check(name, e.next_pc, pred.next_pc);
    check(name, e.slot_valid, pred.slot_valid);
    check(name, e.slot_jump, pred.slot_jump);
    check(name, 1'b0, bpu_flush);
  endtask

  // one resolve cycle with the redirect sampled mid-cycle
  task automatic apply_resolve(input string name, input resolve_t r1, input resolve_t r2,
                               input logic exp_flush, input logic [31:0] exp_jump);
    @(posedge clk);
    res1 <= r1;
    res2 <= r2;
    @(negedge clk);
    check(name, exp_flush, bpu_flush);
    if (exp_flush)
      check(name, exp_jump, bpu_jump_pc);
    @(posedge clk);
    res1 <= '0;
    res2 <= '0;
    model_update(r1, r2, exp_flush);
  endtask

  // one cycle with install low so the jump target enters the queue
  task automatic queue_prediction(input logic [31:0] p);
    @(posedge clk);
    pc      <= p;
    install <= 1'b0;
    @(posedge clk);
    install <= 1'b1;
  endtask

  task automatic cold_lookup();
    for (int i = 0; i < 8; i++)
      lookup_check("cold", rand_pc());
  endtask

  task automatic training_hysteresis();
    logic [31:0] p;
    logic [31:0] q;
    logic [31:0] t;
    logic [31:0] t2;
    p  = rand_pc();
    q  = p ^ 32'h40; // other group
    t  = rand_pc();
    t2 = rand_pc();
    apply_resolve("train_taken", make_res(p, 1'b1, t, JK_BRANCH, 1'b0), '0, 1'b0, '0);
    lookup_check("train_taken", {p[31:4], 4'h0});
    check("train_target", t, pred.next_pc);
    apply_resolve("train_again", make_res(p, 1'b1, t, JK_BRANCH, 1'b0), '0, 1'b0, '0);
    repeat (2)
      apply_resolve("train_not_taken", make_res(p, 1'b0, t, JK_BRANCH, 1'b0), '0, 1'b0, '0);
    lookup_check("train_hysteresis", {p[31:4], 4'h0});
    check("train_hysteresis", 4'b0000, pred.slot_jump);
    apply_resolve("train_dual", make_res(p, 1'b1, t2, JK_BRANCH, 1'b0),
                  make_res(q, 1'b1, t, JK_BRANCH, 1'b0), 1'b0, '0);
    lookup_check("train_dual_1", {p[31:4], 4'h0});
    lookup_check("train_dual_2", {q[31:4], 4'h0});
  endtask

  task automatic tag_and_liveness();
    logic [31:0] p;
    p = {rand_bits(28), 4'h0}; // slot 0 of its group
    apply_resolve("tag_train", make_res(p, 1'b1, rand_pc(), JK_BRANCH, 1'b0), '0, 1'b0, '0);
    lookup_check("tag_miss", p ^ (32'h1 << (IB + 2)));
    lookup_check("slot_live", p | 32'h8);
    check("slot_live", 4'b0000, pred.slot_jump);
  endtask

  task automatic call_and_return();
    logic [31:0] r;
    logic [31:0] a1;
    logic [31:0] a2;
    r  = rand_pc();
    a1 = rand_pc();
    a2 = rand_pc();
    apply_resolve("ret_train", make_res(r, 1'b1, rand_pc(), JK_RETURN, 1'b0), '0, 1'b0, '0);
    apply_resolve("call_one", make_res(a1, 1'b1, rand_pc(), JK_CALL, 1'b0), '0, 1'b0, '0);
    lookup_check("ret_one", {r[31:4], 4'h0});
    check("ret_one", a1 + 32'd4, pred.next_pc);
    apply_resolve("call_two", make_res(a2, 1'b1, rand_pc(), JK_CALL, 1'b0), '0, 1'b0, '0);
    lookup_check("ret_nested", {r[31:4], 4'h0});
    check("ret_nested", a2 + 32'd4, pred.next_pc);
    apply_resolve("ret_pop", make_res(r, 1'b1, a2 + 32'd4, JK_RETURN, 1'b0), '0, 1'b0, '0);
    lookup_check("ret_lifo", {r[31:4], 4'h0});
    check("ret_lifo", a1 + 32'd4, pred.next_pc);
  endtask

  task automatic target_redirect();
    logic [31:0] p;
    logic [31:0] t2;
    logic [31:0] t3;
    p  = rand_pc();
    t2 = rand_pc();
    t3 = rand_pc();
    apply_resolve("redirect_train", make_res(p, 1'b1, rand_pc(), JK_BRANCH, 1'b0), '0, 1'b0, '0);
    queue_prediction({p[31:4], 4'h0});
    apply_resolve("redirect_miss", make_res(p, 1'b1, t2, JK_BRANCH, 1'b1), '0, 1'b1, t2);
    queue_prediction({p[31:4], 4'h0});
    apply_resolve("redirect_match", make_res(p, 1'b1, t2, JK_BRANCH, 1'b1), '0, 1'b0, '0);
    @(posedge clk);
    pc <= {p[31:4], 4'h0};
    repeat (3) @(posedge clk); // install high so nothing is queued
    apply_resolve("redirect_stall", make_res(p, 1'b1, t3, JK_BRANCH, 1'b1), '0, 1'b0, '0);
  endtask

  initial
  begin
    reset   = 1'b1;
    pc      = '0;
    install = 1'b1;
    res1    = '0;
    res2    = '0;
    for (int i = 0; i < ENTRIES; i++)
      m_valid[i] = 1'b0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    cold_lookup();
    training_hysteresis();
    tag_and_liveness();
    call_and_return();
    target_redirect();
    $display("All tests passed");
    $finish;
  end

endmodule

//--- compile.f
hw/bpu_types_pkg.sv
hw/bpu_bus_pkg.sv
hw/btb_pht.sv
hw/return_stack.sv
hw/target_queue.sv
hw/bpu_top.sv
dv/bpu_tb.sv
